// ==== common/ti_mem_consts.svh ====
/*
  TI-99/4A memory map constants
  Bus widths, window compare codes and bank address widths
*/

`ifndef TI_MEM_CONSTS_SVH
`define TI_MEM_CONSTS_SVH

// ==================================================
// Bus widths
// ==================================================
`define TI_ADDR_W      23        // Word address, CPU A15 sits at bit 14
`define TI_DATA_W      16
`define TI_BYTE_W      8         // One byte lane

// ==================================================
// Bank address widths
// ==================================================
`define TI_PAD_AW      9         // Scratchpad, 512 words
`define TI_BANK_AW     14        // GROM ext and RAM exp, 16K words each

// ==================================================
// Window compare codes
// ==================================================
`define TI_PAD_BASE    14'h0020  // addr[22:9], 1K at word 0x4000
`define TI_GROM_BASE   8'h01     // addr[22:15], GROM window
`define TI_RAM_LOW     11'h001   // addr[22:12], low expansion at 0x1000
`define TI_RAM_MID     11'h005   // addr[22:12], 0x5000
`define TI_RAM_HIGH    10'h003   // addr[22:13], 0x6000..0x7FFF
`define TI_CART_LO     3'h1      // addr[22:20], cartridge area 0x100000
`define TI_CART_HI     3'h2      // addr[22:20], up to 0x2FFFFF

// CPU bits 14..12 inside GROM window
`define TI_GEXT_FIRST  3'h3      // First writable GROM slot
`define TI_GEXT_LAST   3'h6      // Last one, 111 stays system side
`define TI_FOLD_CODE   3'h2      // RAM exp fold, top bank bits forced to zero

`endif

// ==== common/ti_mem_pkg.sv ====
/*
  TI-99/4A memory map types
  Vector typedefs for bus words and the folded bank addresses
*/

package ti_mem_pkg;

  `include "ti_mem_consts.svh"

  // ==================================================
  // Bus side
  // ==================================================

  // 23-bit word address as it leaves the CPU bus
  typedef logic [`TI_ADDR_W-1:0] word_addr_t;

  typedef logic [`TI_DATA_W-1:0] data_t;   // Full data word
  typedef logic [`TI_BYTE_W-1:0] byte_t;   // Single lane

  // ==================================================
  // Bank side
  // ==================================================

  // Folded address into a 16K word bank
  typedef logic [`TI_BANK_AW-1:0] bank_addr_t;

  typedef logic [`TI_PAD_AW-1:0] pad_addr_t;  // Scratchpad word index

endpackage

// ==== memory_map/mem_decoder.sv ====
/*
  Memory map decoder
  Splits the CPU word address into scratchpad, GROM extension and
  RAM expansion windows, builds lane write enables and bank addresses
*/

`timescale 1ns/1ps

`include "ti_mem_consts.svh"

module mem_decoder
  import ti_mem_pkg::*;
(
  input  logic       clk,
  input  logic       i_reset,
  input  word_addr_t i_addr,
  input  logic       i_ramwe,       // Active low strobes
  input  logic       i_ramoe,
  input  logic       i_ramlb,
  input  logic       i_ramub,
  output logic       o_pad_we_lo,
  output logic       o_pad_we_hi,
  output logic       o_grom_we_lo,
  output logic       o_grom_we_hi,
  output logic       o_ram_we_lo,
  output logic       o_ram_we_hi,
  output pad_addr_t  o_pad_addr,
  output bank_addr_t o_grom_addr,
  output bank_addr_t o_ram_addr,
  output logic       o_pad_sel_q,   // Registered, lines up with RAM read
  output logic       o_grom_sel_q,
  output logic       o_ram_sel_q
);

  // ==================================================
  // Window decode
  // ==================================================
  logic       pad_sel;
  logic       grom_win;
  logic       grom_sel;
  logic       ram_sel;
  logic [2:0] cpu_hi;     // CPU A15..A13 as word bits 14..12
  logic [1:0] ram_top;

  assign cpu_hi  = i_addr[14:12];
  assign pad_sel = (i_addr[22:9] == `TI_PAD_BASE);

  // Whole GROM window, only part of it is writable
  assign grom_win = (i_addr[22:15] == `TI_GROM_BASE);
  assign grom_sel = grom_win && (cpu_hi >= `TI_GEXT_FIRST) && (cpu_hi <= `TI_GEXT_LAST);

  assign ram_sel = (i_addr[22:12] == `TI_RAM_LOW)
                || (i_addr[22:12] == `TI_RAM_MID)
                || (i_addr[22:13] == `TI_RAM_HIGH)
                || (i_addr[22:20] == `TI_CART_LO)    // Cartridge area
                || (i_addr[22:20] == `TI_CART_HI);

  // Fold 32K of CPU space into one 16K bank
  assign ram_top = (cpu_hi == `TI_FOLD_CODE) ? 2'b00 : i_addr[13:12];

  // ==================================================
  // Bank addresses and lane write enables
  // ==================================================
  assign o_pad_addr  = i_addr[`TI_PAD_AW-1:0];
  assign o_grom_addr = i_addr[`TI_BANK_AW-1:0];
  assign o_ram_addr  = {ram_top, i_addr[11:0]};

  assign o_pad_we_lo  = pad_sel  && !i_ramwe && !i_ramlb;   // Bits 7..0
  assign o_pad_we_hi  = pad_sel  && !i_ramwe && !i_ramub;   // Bits 15..8
  assign o_grom_we_lo = grom_sel && !i_ramwe && !i_ramlb;
  assign o_grom_we_hi = grom_sel && !i_ramwe && !i_ramub;
  assign o_ram_we_lo  = ram_sel  && !i_ramwe && !i_ramlb;
  assign o_ram_we_hi  = ram_sel  && !i_ramwe && !i_ramub;

  // Read selects, one cycle behind the address like the RAM data
  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      o_pad_sel_q  <= 1'b0;
      o_grom_sel_q <= 1'b0;
      o_ram_sel_q  <= 1'b0;
    end
    else
    begin
      o_pad_sel_q  <= pad_sel  && !i_ramoe;  // No output enable, reads zero
      o_grom_sel_q <= grom_sel && !i_ramoe;
      o_ram_sel_q  <= ram_sel  && !i_ramoe;
    end
  end

endmodule

// ==== memory_map/byte_lane_ram.sv ====
/*
  Byte-lane RAM
  Two byte-wide arrays with separate write enables, registered read-first
*/

`timescale 1ns/1ps

module byte_lane_ram
  import ti_mem_pkg::*;
#(
  parameter int ADDR_W = 14       // Depth is 2**ADDR_W words
)
(
  input  logic              clk,
  input  logic              i_we_lo,
  input  logic              i_we_hi,
  input  logic [ADDR_W-1:0] i_addr,
  input  data_t             i_wdata,
  output data_t             o_rdata
);

  localparam int DEPTH = 1 << ADDR_W;

  // ==================================================
  // Storage, one array per lane
  // ==================================================
  byte_t mem_lo [DEPTH];
  byte_t mem_hi [DEPTH];

  byte_t rd_lo;
  byte_t rd_hi;

  // Low lane, old contents come out on a same-cycle write
  always_ff @(posedge clk)
  begin
    rd_lo <= mem_lo[i_addr];
    if (i_we_lo)
    begin
      mem_lo[i_addr] <= i_wdata[7:0];
    end
  end

  // High lane
  always_ff @(posedge clk)
  begin
    rd_hi <= mem_hi[i_addr];
    if (i_we_hi)
    begin
      mem_hi[i_addr] <= i_wdata[15:8];
    end
  end

  assign o_rdata = {rd_hi, rd_lo};  // Upper byte on 15..8

endmodule

// ==== memory_map/read_select.sv ====
/*
  Read data selector
  Picks the bank read word by priority from the registered window selects
*/

`timescale 1ns/1ps

module read_select
  import ti_mem_pkg::*;
(
  input  logic  clk,
  input  logic  i_reset,
  input  logic  i_pad_sel_q,
  input  logic  i_grom_sel_q,
  input  logic  i_ram_sel_q,
  input  data_t i_pad_data,
  input  data_t i_grom_data,
  input  data_t i_ram_data,
  output data_t o_rd_data
);

  // ==================================================
  // Priority mux
  // ==================================================
  always_comb
  begin
    if (i_reset)
    begin
      o_rd_data = '0;            // Held at zero during reset
    end
    else if (i_pad_sel_q)
    begin
      o_rd_data = i_pad_data;    // Scratchpad first
    end
    else if (i_grom_sel_q)
    begin
      o_rd_data = i_grom_data;   // Cartridge GROM space
    end
    else if (i_ram_sel_q)
    begin
      o_rd_data = i_ram_data;
    end
    else
    begin
      o_rd_data = '0;            // Unmapped, ROM and system GROM
    end
  end

endmodule

// ==== logic/ti_memory_top.sv ====
/*
  TI-99/4A on-chip memory map
  Decoder, scratchpad, GROM extension and RAM expansion banks,
  read word returned one clock after the address
*/

`timescale 1ns/1ps

`include "ti_mem_consts.svh"

module ti_memory_top
  import ti_mem_pkg::*;
(
  input  logic       clk,
  input  logic       i_reset,
  input  word_addr_t i_addr,
  input  data_t      i_wdata,
  input  logic       i_ramwe,
  input  logic       i_ramoe,
  input  logic       i_ramlb,
  input  logic       i_ramub,
  output data_t      o_rd_data
);

  logic       pad_we_lo, pad_we_hi;
  logic       grom_we_lo, grom_we_hi;
  logic       ram_we_lo, ram_we_hi;
  pad_addr_t  pad_addr;
  bank_addr_t grom_addr, ram_addr;
  logic       pad_sel_q, grom_sel_q, ram_sel_q;
  data_t      pad_data, grom_data, ram_data;

  // ==================================================
  // Address decode
  // ==================================================
  mem_decoder mem_decoder_i (
    .clk(clk), .i_reset(i_reset), .i_addr(i_addr),
    .i_ramwe(i_ramwe), .i_ramoe(i_ramoe), .i_ramlb(i_ramlb), .i_ramub(i_ramub),
    .o_pad_we_lo(pad_we_lo), .o_pad_we_hi(pad_we_hi),
    .o_grom_we_lo(grom_we_lo), .o_grom_we_hi(grom_we_hi),
    .o_ram_we_lo(ram_we_lo), .o_ram_we_hi(ram_we_hi),
    .o_pad_addr(pad_addr), .o_grom_addr(grom_addr), .o_ram_addr(ram_addr),
    .o_pad_sel_q(pad_sel_q), .o_grom_sel_q(grom_sel_q), .o_ram_sel_q(ram_sel_q)
  );

  // ==================================================
  // Banks
  // ==================================================
  byte_lane_ram #(.ADDR_W(`TI_PAD_AW)) pad_ram (        // 1K scratchpad
    .clk(clk), .i_we_lo(pad_we_lo), .i_we_hi(pad_we_hi),
    .i_addr(pad_addr), .i_wdata(i_wdata), .o_rdata(pad_data)
  );

  byte_lane_ram #(.ADDR_W(`TI_BANK_AW)) grom_ext_ram (  // Writable GROM
    .clk(clk), .i_we_lo(grom_we_lo), .i_we_hi(grom_we_hi),
    .i_addr(grom_addr), .i_wdata(i_wdata), .o_rdata(grom_data)
  );

  byte_lane_ram #(.ADDR_W(`TI_BANK_AW)) ram_exp_ram (   // Folded expansion
    .clk(clk), .i_we_lo(ram_we_lo), .i_we_hi(ram_we_hi),
    .i_addr(ram_addr), .i_wdata(i_wdata), .o_rdata(ram_data)
  );

  read_select read_select_i (
    .clk(clk), .i_reset(i_reset),
    .i_pad_sel_q(pad_sel_q), .i_grom_sel_q(grom_sel_q), .i_ram_sel_q(ram_sel_q),
    .i_pad_data(pad_data), .i_grom_data(grom_data), .i_ram_data(ram_data),
    .o_rd_data(o_rd_data)
  );

endmodule

// ==== sim/tb_clock_gen.sv ====
/*
  Testbench clock and reset
  10 ns clock, synchronous reset held for the first 8 rising edges
*/

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int HALF_NS      = 5,
  parameter int RESET_CYCLES = 8
)
(
  output logic clk,
  output logic o_reset
);

  initial
  begin
    clk     = 1'b0;
    o_reset = 1'b1;
    forever
      #HALF_NS clk = ~clk;
  end

  // Drop reset right after the last reset edge
  initial
  begin
    repeat (RESET_CYCLES) @(posedge clk);
    o_reset <= 1'b0;
  end

endmodule

// ==== sim/mem_checker.sv ====
/*
  Read data checker
  Compares the DUT read word one cycle after each flagged read,
  and the zero output while reset is applied
*/

`timescale 1ns/1ps

module mem_checker
  import ti_mem_pkg::*;
(
  input  logic  clk,
  input  logic  i_reset,
  input  logic  i_check,       // Read row on the bus this cycle
  input  data_t i_rd_data,
  output int    o_checked,     // Table reads compared so far
  output int    o_fail_count
);

  string name_q [$];           // Pending reads, oldest first
  data_t exp_q  [$];

  logic  check_q      = 1'b0;  // Read sampled by the DUT at the last edge
  logic  reset_q      = 1'b0;
  logic  reset_done   = 1'b0;
  data_t reset_val    = '0;    // Last nonzero word seen in reset
  int    reset_cycles = 0;
  int    test_count   = 0;

  // Queued by the stimulus loop when it drives a read row
  task automatic expect_read(input string name, input data_t expected);
    name_q.push_back(name);
    exp_q.push_back(expected);
  endtask

  task automatic report_result(input string name, input data_t expected, input data_t actual);
    test_count++;
    if (actual !== expected)
    begin
      o_fail_count++;
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
    end
    else
      $display("ok   %s: %h", name, actual);
  endtask

  task automatic print_totals(input int assert_fails);
    $display("Totals: %0d tests, %0d failed, %0d assertion failures",
             test_count, o_fail_count, assert_fails);
  endtask

  initial
  begin
    o_checked    = 0;
    o_fail_count = 0;
  end

  always @(posedge clk)
  begin
    check_q <= i_check;
    reset_q <= i_reset;
  end

  // ==================================================
  // Compare mid cycle, output settled
  // ==================================================
  always @(negedge clk)
  begin
    if (reset_q)
    begin
      reset_cycles++;
      if (i_rd_data !== '0)
        reset_val = i_rd_data;
    end
    else if (reset_cycles > 0 && !reset_done)
    begin
      reset_done = 1'b1;         // One line for the whole reset window
      report_result("reset_clears_read", '0, reset_val);
    end

    if (check_q)
    begin
      if (name_q.size() == 0)
      begin
        o_fail_count++;
        $display("Checker error: a read was flagged but no expected value was queued");
      end
      else
        report_result(name_q.pop_front(), exp_q.pop_front(), i_rd_data);
      o_checked++;
    end
  end

endmodule

// ==== sim/mem_properties.sv ====
/*
  Read timing properties
  Bound into the memory map top, zero read data after reset and after
  reads without output enable
*/

`timescale 1ns/1ps

module mem_properties
  import ti_mem_pkg::*;
(
  input logic  clk,
  input logic  i_reset,
  input logic  i_ramoe,
  input data_t i_rd_data
);

  int fail_count = 0;  // Failed assertions so far

  // Output held at zero in the cycle after a reset edge
  reset_clears_read: assert property (@(posedge clk) i_reset |=> (i_rd_data == '0))
  else
  begin
    fail_count++;
    $error("read data not zero in the cycle after reset");
  end

  // No output enable, no data
  no_oe_reads_zero: assert property (
    @(posedge clk) disable iff (i_reset) i_ramoe |=> (i_rd_data == '0))
  else
  begin
    fail_count++;
    $error("read data not zero after a read with output enable high");
  end

endmodule

bind ti_memory_top mem_properties mem_properties_i (
  .clk(clk), .i_reset(i_reset), .i_ramoe(i_ramoe), .i_rd_data(o_rd_data)
);

// ==== sim/tb_ti_memory.sv ====
/*
  Memory map testbench
  Builds a table of bus cycles with expected read words from a reference
  model, drives one row per clock and hands the reads to the checker
*/

`timescale 1ns/1ps

module tb_ti_memory
  import ti_mem_pkg::*;
();

  localparam int CLK_NS        = 10;
  localparam int RESET_CYCLES  = 8;
  localparam int MARGIN_CYCLES = 40;  // Reset release and drain

  logic       clk;
  logic       rst;
  word_addr_t addr;
  data_t      wdata;
  data_t      rd_data;
  logic       ramwe, ramoe, ramlb, ramub;   // Active low
  logic       check;
  int         checked;
  int         fail_count;
  int         assert_fails;

  // ==================================================
  // Stimulus table, one entry per clock
  // ==================================================
  string      row_name  [$];
  word_addr_t row_addr  [$];
  data_t      row_data  [$];
  logic       row_we    [$];
  logic       row_oe    [$];
  logic       row_lb    [$];
  logic       row_ub    [$];
  logic       row_check [$];
  data_t      row_exp   [$];

  logic [15:0] model_mem [int];       // Expected contents by window and bank
  logic [31:0] lcg_state   = 32'd75;
  int          check_rows  = 0;
  bit          table_ready = 1'b0;
  int          watchdog_ns = 0;

  tb_clock_gen #(.HALF_NS(CLK_NS / 2), .RESET_CYCLES(RESET_CYCLES)) tb_clock_gen_i (
    .clk(clk), .o_reset(rst)
  );

  ti_memory_top ti_memory_top_i (
    .clk(clk), .i_reset(rst), .i_addr(addr), .i_wdata(wdata),
    .i_ramwe(ramwe), .i_ramoe(ramoe), .i_ramlb(ramlb), .i_ramub(ramub),
    .o_rd_data(rd_data)
  );

  mem_checker mem_checker_i (
    .clk(clk), .i_reset(rst), .i_check(check), .i_rd_data(rd_data),
    .o_checked(checked), .o_fail_count(fail_count)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic data_t random_word();
    lcg_state = lcg_next(lcg_state);
    return lcg_state[31:16];           // Upper bits, better spread
  endfunction

  // Window in bits 17..16 and bank index below, -1 when nothing is mapped
  function automatic int model_key(input word_addr_t a);
    int slot;
    slot = a[14:12];                   // CPU A15..A13
    if (a >= 23'h004000 && a <= 23'h0041FF)
      return 32'h10000 | a[8:0];
    if (a >= 23'h008000 && a <= 23'h00FFFF && slot >= 3 && slot <= 6)
      return 32'h20000 | a[13:0];
    if ((a >= 23'h001000 && a <= 23'h001FFF) || (a >= 23'h005000 && a <= 23'h007FFF)
        || (a >= 23'h100000 && a <= 23'h2FFFFF))
    begin
      if (slot == 2)
        return 32'h30000 | a[11:0];    // Top bank bits forced to zero
      return 32'h30000 | a[13:0];
    end
    return -1;
  endfunction

  task automatic add_row(input string name, input word_addr_t a, input data_t d,
                         input logic we_n, input logic oe_n, input logic lb_n,
                         input logic ub_n, input logic chk);
    int    key;
    data_t expected;
    data_t word;
    key = model_key(a);
    // Expected word is the contents before this cycle's write
    if (oe_n || key < 0)
      expected = '0;
    else if (model_mem.exists(key))
      expected = model_mem[key];
    else
      expected = 'x;
    if (!we_n && key >= 0)
    begin
      word = model_mem.exists(key) ? model_mem[key] : 16'hxxxx;
      if (!lb_n)
        word[7:0] = d[7:0];
      if (!ub_n)
        word[15:8] = d[15:8];
      model_mem[key] = word;
    end
    row_name.push_back(name);
    row_addr.push_back(a);
    row_data.push_back(d);
    row_we.push_back(we_n);
    row_oe.push_back(oe_n);
    row_lb.push_back(lb_n);
    row_ub.push_back(ub_n);
    row_check.push_back(chk);
    row_exp.push_back(expected);
    if (chk)
      check_rows++;
  endtask

  task automatic write_word(input string name, input word_addr_t a,
                            input logic lb_n, input logic ub_n);
    add_row(name, a, random_word(), 1'b0, 1'b1, lb_n, ub_n, 1'b0);
  endtask

  task automatic read_word(input string name, input word_addr_t a);
    add_row(name, a, '0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1);
  endtask

  task automatic write_while_reading(input string name, input word_addr_t a);
    add_row(name, a, random_word(), 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
  endtask

  task automatic read_without_oe(input string name, input word_addr_t a);
    add_row(name, a, '0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1);
  endtask

  task automatic build_table();
    // Scratchpad ends, back-to-back reads
    write_word("pad_wr_first", 23'h004000, 1'b0, 1'b0);
    write_word("pad_wr_last", 23'h0041FF, 1'b0, 1'b0);
    read_word("pad_rd_first", 23'h004000);
    read_word("pad_rd_last", 23'h0041FF);
    // Byte lanes
    write_word("lane_wr_full", 23'h004010, 1'b0, 1'b0);
    write_word("lane_wr_lo", 23'h004010, 1'b0, 1'b1);
    read_word("lane_rd_keep_hi", 23'h004010);
    write_word("lane_wr_hi", 23'h004010, 1'b1, 1'b0);
    read_word("lane_rd_keep_lo", 23'h004010);
    write_while_reading("lane_rd_old_word", 23'h004010);
    read_word("lane_rd_new_word", 23'h004010);
    // RAM expansion folding and cartridge aliases
    write_word("ram_wr_1234", 23'h001234, 1'b0, 1'b0);
    read_word("ram_rd_alias_5234", 23'h005234);
    write_word("ram_wr_6010", 23'h006010, 1'b0, 1'b0);
    write_word("ram_wr_7010", 23'h007010, 1'b0, 1'b0);
    read_word("ram_rd_6010", 23'h006010);
    read_word("ram_rd_7010", 23'h007010);
    write_word("cart_wr_2a6010", 23'h2A6010, 1'b0, 1'b0);
    read_word("cart_rd_alias_6010", 23'h006010);
    write_word("cart_wr_fold_102345", 23'h102345, 1'b0, 1'b0);
    read_word("cart_rd_fold_100345", 23'h100345);
    // GROM extension slots 011 to 110
    write_word("grom_wr_slot3", 23'h00B010, 1'b0, 1'b0);
    write_word("grom_wr_slot4", 23'h00C010, 1'b0, 1'b0);
    write_word("grom_wr_slot5", 23'h00D010, 1'b0, 1'b0);
    write_word("grom_wr_slot6", 23'h00E010, 1'b0, 1'b0);
    read_word("grom_rd_slot3", 23'h00B010);
    read_word("grom_rd_slot4", 23'h00C010);
    read_word("grom_rd_slot5", 23'h00D010);
    read_word("grom_rd_slot6", 23'h00E010);
    // System GROM slots and system ROM
    read_word("grom_rd_slot0", 23'h008010);
    read_word("grom_rd_slot1", 23'h009010);
    read_word("grom_rd_slot2", 23'h00A010);
    read_word("grom_rd_slot7", 23'h00F010);
    read_word("rom_rd_zero", 23'h000010);
    // Writes outside the windows, same low bank bits as live words
    write_word("unmap_wr_3010", 23'h003010, 1'b0, 1'b0);
    write_word("unmap_wr_4210", 23'h004210, 1'b0, 1'b0);
    write_word("unmap_wr_307010", 23'h307010, 1'b0, 1'b0);
    write_word("grom_wr_slot7", 23'h00F010, 1'b0, 1'b0);
    write_word("rom_wr_0010", 23'h000010, 1'b0, 1'b0);
    read_word("unmap_rd_3010", 23'h003010);
    read_word("unmap_rd_4210", 23'h004210);
    read_word("unmap_rd_307010", 23'h307010);
    read_word("pad_rd_after_unmap", 23'h004010);
    read_word("grom_rd_after_unmap", 23'h00B010);
    read_word("ram_rd_after_unmap", 23'h007010);
    // Output enable high
    read_without_oe("pad_rd_no_oe", 23'h004000);
    read_without_oe("ram_rd_no_oe", 23'h006010);
  endtask

  // ==================================================
  // Apply the table
  // ==================================================
  initial
  begin
    addr  = '0;
    wdata = '0;
    ramwe = 1'b1;
    ramoe = 1'b1;
    ramlb = 1'b1;
    ramub = 1'b1;
    check = 1'b0;
    build_table();
    watchdog_ns = (row_name.size() + RESET_CYCLES + MARGIN_CYCLES) * CLK_NS;
    table_ready = 1'b1;
    @(posedge clk);
    while (rst)
      @(posedge clk);
    foreach (row_name[i])
    begin
      addr  <= row_addr[i];
      wdata <= row_data[i];
      ramwe <= row_we[i];
      ramoe <= row_oe[i];
      ramlb <= row_lb[i];
      ramub <= row_ub[i];
      check <= row_check[i];
      if (row_check[i])
        mem_checker_i.expect_read(row_name[i], row_exp[i]);
      @(posedge clk);
    end
    ramwe <= 1'b1;                     // Bus idle
    ramoe <= 1'b1;
    ramlb <= 1'b1;
    ramub <= 1'b1;
    check <= 1'b0;
    while (checked < check_rows)
      @(posedge clk);
    @(negedge clk);                    // Last read's assertion edge is behind us
    assert_fails = ti_memory_top_i.mem_properties_i.fail_count;
    mem_checker_i.print_totals(assert_fails);
    if (fail_count == 0 && assert_fails == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  // Watchdog
  initial
  begin
    wait (table_ready);
    #(watchdog_ns);
    $display("Timeout after %0d ns, the read checks did not complete", watchdog_ns);
    $display("Testbench failed");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+common
common/ti_mem_pkg.sv
memory_map/mem_decoder.sv
memory_map/byte_lane_ram.sv
memory_map/read_select.sv
logic/ti_memory_top.sv
sim/tb_clock_gen.sv
sim/mem_checker.sv
sim/mem_properties.sv
sim/tb_ti_memory.sv

// ==== Bender.yml ====
package:
  name: ti_memory

export_include_dirs:
  - common

sources:
  # Design
  - include_dirs:
      - common
    files:
      - common/ti_mem_pkg.sv
      - memory_map/mem_decoder.sv
      - memory_map/byte_lane_ram.sv
      - memory_map/read_select.sv
      - logic/ti_memory_top.sv

  # Testbench
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/tb_clock_gen.sv
      - sim/mem_checker.sv
      - sim/mem_properties.sv
      - sim/tb_ti_memory.sv
